//--- rtl/vfpu_eu_pkg.sv
// Execution unit select definitions for the vector FP issue control
// Unit count, one-hot select type, unit bit positions and mtvr opcode type

package vfpu_eu_pkg;

  //------------------------------------------------------------
  // Execution unit select
  //------------------------------------------------------------

  // Number of execution units behind one pipe
  localparam int EU_WIDTH = 12;

  // One-hot select, one bit per unit
  typedef logic [EU_WIDTH-1:0] eu_sel_t;

  //------------------------------------------------------------
  // Unit bit positions
  //------------------------------------------------------------

  // ALU unit, target of mtvr ops with opcode bit 0, 1 or 4 set
  localparam int EU_BIT_ALU = 0;

  // FMA unit, also drives the early select to the datapath
  localparam int EU_BIT_FMAU = 4;

  // Move unit, target of every other mtvr op
  localparam int EU_BIT_MOV = 7;

  //------------------------------------------------------------
  // Move-to-vector-register opcode
  //------------------------------------------------------------

  // Opcode width as delivered by the integer pipe
  localparam int MTVR_INST_WIDTH = 5;

  // Raw mtvr opcode
  typedef logic [MTVR_INST_WIDTH-1:0] mtvr_inst_t;

endpackage

//--- rtl/vfpu_pipe_pkg.sv
// Pipe level bundles for the vector FP issue control
// Issue inputs, datapath pre-valid hints, divide returns and stage valids

package vfpu_pipe_pkg;

  //------------------------------------------------------------
  // Pipeline depth
  //------------------------------------------------------------

  // Instruction valid stages EX1 to EX5
  localparam int STAGE_CNT = 5;

  //------------------------------------------------------------
  // Issue side
  //------------------------------------------------------------

  // One pipe's issue strobes, sampled at the clock edge
  typedef struct packed {
    // Register file issue
    logic                    rf_sel;
    vfpu_eu_pkg::eu_sel_t    rf_eu_sel;
    // Move from an integer pipe
    logic                    mtvr_vld;
    vfpu_eu_pkg::mtvr_inst_t mtvr_inst;
    // Instruction writes a destination
    logic                    dst_vld;
  } issue_t;

  //------------------------------------------------------------
  // Datapath hints
  //------------------------------------------------------------

  // Pre-valids qualified here with the stage before
  typedef struct packed {
    logic ex1_data;
    logic ex2_data;
    logic ex3_data;
    logic ex3_fwd;
    logic ex4_fwd;
  } dp_pre_t;

  // Divide and sqrt results coming back into pipe 6
  typedef struct packed {
    // Divide/sqrt op entering EX2
    logic ex2_dsu;
    // Divide result entering EX2
    logic ex2_divu;
    // Divide/sqrt op entering EX5
    logic ex5_dsu;
  } div_ret_t;

  //------------------------------------------------------------
  // Registered stage valids
  //------------------------------------------------------------

  typedef struct packed {
    // Bit 0 is EX1
    logic [STAGE_CNT-1:0] inst_vld;
    // EX1 to EX3
    logic [2:0]           data_vld;
    // EX3 and EX4
    logic [1:0]           fwd_vld;
    // EX1 and EX2
    logic [1:0]           mfvr_vld;
  } stage_vld_t;

endpackage

//--- rtl/vfpu_eu_sel.sv
// Execution unit select for one pipe
// mtvr opcode decode, EX1 select register and early FMA select
`timescale 1ns/1ns

module vfpu_eu_sel (
  input  logic                  ctrl_ex1_pipe6_clk,
  input  logic                  cpurst_b,
  input  logic                  flush,
  input  vfpu_pipe_pkg::issue_t issue,
  input  logic                  ex1_inst_vld,
  output logic                  fmau_sel,
  output vfpu_eu_pkg::eu_sel_t  eu_sel
);

  import vfpu_eu_pkg::*;
  import vfpu_pipe_pkg::*;

  // Unit picked by the mtvr opcode
  eu_sel_t mtvr_eu_sel;
  // Select chosen for the instruction entering EX1
  eu_sel_t issue_eu_sel;
  // Select held for the EX1 instruction
  eu_sel_t ex1_eu_sel_q;
  logic    ex1_entry;

  //------------------------------------------------------------
  // Issue cycle select
  //------------------------------------------------------------

  // Any issue source fills EX1
  assign ex1_entry = issue.rf_sel | issue.mtvr_vld;

  // Integer-side ops with opcode bits 0, 1 or 4 go to the ALU
  // Everything else is a plain move
  assign mtvr_eu_sel = (|issue.mtvr_inst[1:0] | issue.mtvr_inst[4])
                     ? eu_sel_t'(1) << EU_BIT_ALU
                     : eu_sel_t'(1) << EU_BIT_MOV;

  // mtvr wins over register file issue
  assign issue_eu_sel = issue.mtvr_vld ? mtvr_eu_sel : issue.rf_eu_sel;

  // Early FMA select for the datapath, same cycle as issue
  assign fmau_sel = ex1_entry & issue_eu_sel[EU_BIT_FMAU];

  //------------------------------------------------------------
  // EX1 select register
  //------------------------------------------------------------

  always_ff @(posedge ctrl_ex1_pipe6_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex1_eu_sel_q <= '0;
    end
    else if (flush)
    begin
      ex1_eu_sel_q <= '0;
    end
    else
    begin
      ex1_eu_sel_q <= issue_eu_sel;
    end
  end

  // Stale select hidden while EX1 is empty
  assign eu_sel = ex1_eu_sel_q & {EU_WIDTH{ex1_inst_vld}};

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------

  // A valid EX1 instruction names exactly one unit
  a_eu_sel_onehot: assert property (
    @(posedge ctrl_ex1_pipe6_clk) disable iff (!cpurst_b)
    ex1_inst_vld |-> $onehot(eu_sel)
  );

endmodule

//--- rtl/vfpu_pipe_ctrl.sv
// Valid pipeline for one vector FP pipe, EX1 to EX5
// Data, forward and mfvr valids with optional divide return entry
`timescale 1ns/1ns

module vfpu_pipe_ctrl #(
  // Pipe 6 takes divide and sqrt returns, pipe 7 does not
  parameter bit DIV_RETURN_EN = 1'b0
) (
  input  logic                      ctrl_ex1_pipe6_clk,
  input  logic                      cpurst_b,
  input  logic                      flush,
  input  vfpu_pipe_pkg::issue_t     issue,
  input  vfpu_pipe_pkg::dp_pre_t    dp_pre,
  input  vfpu_pipe_pkg::div_ret_t   div_ret,
  output vfpu_pipe_pkg::stage_vld_t vld,
  output vfpu_eu_pkg::eu_sel_t      eu_sel,
  output logic                      fmau_sel
);

  import vfpu_eu_pkg::*;
  import vfpu_pipe_pkg::*;

  // Next state of every stage valid
  stage_vld_t vld_nxt;
  // Instruction entering EX1 this cycle
  logic       ex1_entry;
  // Divide return into EX2 and into EX5
  logic       div_ex2;
  logic       div_ex5;

  //------------------------------------------------------------
  // Issue entry
  //------------------------------------------------------------

  // EX1 fed from register file issue or an mtvr op
  assign ex1_entry = issue.rf_sel | issue.mtvr_vld;

  //------------------------------------------------------------
  // Divide return entry
  //------------------------------------------------------------

  generate
    if (DIV_RETURN_EN)
    begin : g_div_ret
      // Divide/sqrt op or divide result joins at EX2
      assign div_ex2 = div_ret.ex2_dsu | div_ret.ex2_divu;
      // Divide/sqrt op finishing joins at EX5
      assign div_ex5 = div_ret.ex5_dsu;
    end
    else
    begin : g_no_div_ret
      // No divider behind this pipe
      assign div_ex2 = 1'b0;
      assign div_ex5 = 1'b0;
    end
  endgenerate

  //------------------------------------------------------------
  // Next state
  //------------------------------------------------------------

  always_comb
  begin
    vld_nxt = '0;

    // Instruction valid chain
    vld_nxt.inst_vld[0] = ex1_entry;
    for (int i = 1; i < STAGE_CNT; i++)
    begin
      vld_nxt.inst_vld[i] = vld.inst_vld[i-1];
    end
    // Divide returns enter mid pipe without an EX1 slot
    vld_nxt.inst_vld[1] = vld.inst_vld[0] | div_ex2;
    vld_nxt.inst_vld[STAGE_CNT-1] = vld.inst_vld[STAGE_CNT-2] | div_ex5;

    // EX1 data, hint only counts for register file issue
    // mtvr always brings its operand
    vld_nxt.data_vld[0] = (dp_pre.ex1_data & issue.rf_sel) | issue.mtvr_vld;
    // EX2 data, divide returns carry their result
    vld_nxt.data_vld[1] = (dp_pre.ex2_data & vld.inst_vld[0]) | div_ex2;
    // EX3 data
    vld_nxt.data_vld[2] = dp_pre.ex3_data & vld.inst_vld[1];

    // Forward valids at EX3 and EX4
    vld_nxt.fwd_vld[0] = dp_pre.ex3_fwd & vld.inst_vld[1];
    vld_nxt.fwd_vld[1] = dp_pre.ex4_fwd & vld.inst_vld[2];

    // mfvr destination valid, EX1 then EX2
    vld_nxt.mfvr_vld[0] = ex1_entry & issue.dst_vld;
    vld_nxt.mfvr_vld[1] = vld.mfvr_vld[0];
  end

  //------------------------------------------------------------
  // Stage registers
  //------------------------------------------------------------

  // Flush empties every stage ahead of any new entry
  always_ff @(posedge ctrl_ex1_pipe6_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      vld <= '0;
    end
    else if (flush)
    begin
      vld <= '0;
    end
    else
    begin
      vld <= vld_nxt;
    end
  end

  //------------------------------------------------------------
  // Execution unit select
  //------------------------------------------------------------

  vfpu_eu_sel u_eu_sel (
    .ctrl_ex1_pipe6_clk (ctrl_ex1_pipe6_clk),
    .cpurst_b           (cpurst_b),
    .flush              (flush),
    .issue              (issue),
    .ex1_inst_vld       (vld.inst_vld[0]),
    .fmau_sel           (fmau_sel),
    .eu_sel             (eu_sel)
  );

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------

  // Forward valid only for an instruction held in EX3
  a_fwd_ex3_has_inst: assert property (
    @(posedge ctrl_ex1_pipe6_clk) disable iff (!cpurst_b)
    vld.fwd_vld[0] |-> vld.inst_vld[2]
  );

  // Forward valid only for an instruction held in EX4
  a_fwd_ex4_has_inst: assert property (
    @(posedge ctrl_ex1_pipe6_clk) disable iff (!cpurst_b)
    vld.fwd_vld[1] |-> vld.inst_vld[3]
  );

  // mfvr destination never without its EX1 instruction
  a_mfvr_ex1_has_inst: assert property (
    @(posedge ctrl_ex1_pipe6_clk) disable iff (!cpurst_b)
    vld.mfvr_vld[0] |-> vld.inst_vld[0]
  );

endmodule

//--- rtl/vfpu_ctrl.sv
// Vector FP issue control top
// Pipe 6 with divide returns and pipe 7 without
`timescale 1ns/1ns

module vfpu_ctrl (
  input  logic                      ctrl_ex1_pipe6_clk,
  input  logic                      cpurst_b,
  // Pipeline flush from retire
  input  logic                      flush,

  // Issue into each pipe
  input  vfpu_pipe_pkg::issue_t     pipe6_issue,
  input  vfpu_pipe_pkg::issue_t     pipe7_issue,

  // Datapath pre-valid hints
  input  vfpu_pipe_pkg::dp_pre_t    pipe6_dp_pre,
  input  vfpu_pipe_pkg::dp_pre_t    pipe7_dp_pre,

  // Divide and sqrt returns, pipe 6 only
  input  vfpu_pipe_pkg::div_ret_t   pipe6_div_ret,

  // Registered stage valids
  output vfpu_pipe_pkg::stage_vld_t pipe6_vld,
  output vfpu_pipe_pkg::stage_vld_t pipe7_vld,

  // EX1 unit selects
  output vfpu_eu_pkg::eu_sel_t      pipe6_eu_sel,
  output vfpu_eu_pkg::eu_sel_t      pipe7_eu_sel,

  // Early FMA selects in the issue cycle
  output logic                      pipe6_fmau_sel,
  output logic                      pipe7_fmau_sel
);

  import vfpu_eu_pkg::*;
  import vfpu_pipe_pkg::*;

  //------------------------------------------------------------
  // Pipe 6
  //------------------------------------------------------------

  // Divider results join this pipe at EX2 and EX5
  vfpu_pipe_ctrl #(
    .DIV_RETURN_EN (1'b1)
  ) u_pipe6 (
    .ctrl_ex1_pipe6_clk (ctrl_ex1_pipe6_clk),
    .cpurst_b           (cpurst_b),
    .flush              (flush),
    .issue              (pipe6_issue),
    .dp_pre             (pipe6_dp_pre),
    .div_ret            (pipe6_div_ret),
    .vld                (pipe6_vld),
    .eu_sel             (pipe6_eu_sel),
    .fmau_sel           (pipe6_fmau_sel)
  );

  //------------------------------------------------------------
  // Pipe 7
  //------------------------------------------------------------

  // No divider, return port stays open
  vfpu_pipe_ctrl #(
    .DIV_RETURN_EN (1'b0)
  ) u_pipe7 (
    .ctrl_ex1_pipe6_clk (ctrl_ex1_pipe6_clk),
    .cpurst_b           (cpurst_b),
    .flush              (flush),
    .issue              (pipe7_issue),
    .dp_pre             (pipe7_dp_pre),
    .div_ret            (),
    .vld                (pipe7_vld),
    .eu_sel             (pipe7_eu_sel),
    .fmau_sel           (pipe7_fmau_sel)
  );

endmodule

//--- dv/vfpu_ctrl_tb.sv
// Testbench for the vector FP issue control
// Clock, reset, stimulus table, cycle model, checker and watchdog
`timescale 1ns/1ns

module vfpu_ctrl_tb;

  import vfpu_eu_pkg::*;
  import vfpu_pipe_pkg::*;

  // One cycle of stimulus, plus the expected pipe 6 EX1..EX5 valids
  typedef struct packed {
    logic       flush;
    issue_t     iss6;
    issue_t     iss7;
    dp_pre_t    pre6;
    dp_pre_t    pre7;
    div_ret_t   div6;
    logic       exp_en;
    logic [4:0] exp6_inst;
  } row_t;

  localparam issue_t   NO_ISS      = '0;
  localparam dp_pre_t  PRE_ALL     = '1;
  localparam dp_pre_t  PRE_NONE    = '0;
  localparam dp_pre_t  PRE_MIX     = 5'b10101;
  localparam div_ret_t DIV_NONE    = 3'b000;
  localparam div_ret_t DIV_EX2_DSU = 3'b100;
  localparam div_ret_t DIV_EX2_DIV = 3'b010;
  localparam div_ret_t DIV_EX5_DSU = 3'b001;

  logic       ctrl_ex1_pipe6_clk;
  logic       cpurst_b;
  logic       flush;
  issue_t     pipe6_issue;
  issue_t     pipe7_issue;
  dp_pre_t    pipe6_dp_pre;
  dp_pre_t    pipe7_dp_pre;
  div_ret_t   pipe6_div_ret;
  stage_vld_t pipe6_vld;
  stage_vld_t pipe7_vld;
  eu_sel_t    pipe6_eu_sel;
  eu_sel_t    pipe7_eu_sel;
  logic       pipe6_fmau_sel;
  logic       pipe7_fmau_sel;

  // Model state, one copy per pipe
  stage_vld_t  m6;
  stage_vld_t  m7;
  eu_sel_t     q6;
  eu_sel_t     q7;
  row_t        rows[$];
  logic [63:0] wd_limit;

  vfpu_ctrl dut_i (
    .ctrl_ex1_pipe6_clk (ctrl_ex1_pipe6_clk),
    .cpurst_b           (cpurst_b),
    .flush              (flush),
    .pipe6_issue        (pipe6_issue),
    .pipe7_issue        (pipe7_issue),
    .pipe6_dp_pre       (pipe6_dp_pre),
    .pipe7_dp_pre       (pipe7_dp_pre),
    .pipe6_div_ret      (pipe6_div_ret),
    .pipe6_vld          (pipe6_vld),
    .pipe7_vld          (pipe7_vld),
    .pipe6_eu_sel       (pipe6_eu_sel),
    .pipe7_eu_sel       (pipe7_eu_sel),
    .pipe6_fmau_sel     (pipe6_fmau_sel),
    .pipe7_fmau_sel     (pipe7_fmau_sel)
  );

  initial
  begin
    ctrl_ex1_pipe6_clk = 1'b0;
    forever #5 ctrl_ex1_pipe6_clk = ~ctrl_ex1_pipe6_clk;
  end

  //------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------

  // Unit chosen at issue, mtvr opcode bits 0, 1, 4 mean ALU
  function automatic eu_sel_t pick_sel(issue_t iss);
    eu_sel_t sel;
    if (!iss.mtvr_vld)
    begin
      sel = iss.rf_eu_sel;
    end
    else if (iss.mtvr_inst[0] || iss.mtvr_inst[1] || iss.mtvr_inst[4])
    begin
      sel = eu_sel_t'(1) << EU_BIT_ALU;
    end
    else
    begin
      sel = eu_sel_t'(1) << EU_BIT_MOV;
    end
    return sel;
  endfunction

  function automatic logic exp_fmau(issue_t iss);
    eu_sel_t sel;
    sel = pick_sel(iss);
    return (iss.rf_sel | iss.mtvr_vld) & sel[EU_BIT_FMAU];
  endfunction

  // One rising edge of a pipe, flush handled by the caller
  function automatic stage_vld_t next_vld(stage_vld_t s, issue_t iss, dp_pre_t pre,
                                          div_ret_t dr);
    stage_vld_t n;
    logic       entry;
    logic       div2;
    entry = iss.rf_sel | iss.mtvr_vld;
    div2 = dr.ex2_dsu | dr.ex2_divu;
    n.inst_vld = {s.inst_vld[3] | dr.ex5_dsu, s.inst_vld[2], s.inst_vld[1],
                  s.inst_vld[0] | div2, entry};
    n.data_vld[0] = (pre.ex1_data & iss.rf_sel) | iss.mtvr_vld;
    n.data_vld[1] = (pre.ex2_data & s.inst_vld[0]) | div2;
    n.data_vld[2] = pre.ex3_data & s.inst_vld[1];
    n.fwd_vld[0] = pre.ex3_fwd & s.inst_vld[1];
    n.fwd_vld[1] = pre.ex4_fwd & s.inst_vld[2];
    n.mfvr_vld[0] = entry & iss.dst_vld;
    n.mfvr_vld[1] = s.mfvr_vld[0];
    return n;
  endfunction

  //------------------------------------------------------------
  // Checker
  //------------------------------------------------------------

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: time %0t signal %s got 'h%0h expected 'h%0h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Output mismatch, run stopped");
    end
  endtask

  task automatic compare_pipe(string p, stage_vld_t got, stage_vld_t exp,
                              eu_sel_t got_sel, eu_sel_t q);
    check({p, "_vld.inst_vld"}, 32'(got.inst_vld), 32'(exp.inst_vld));
    check({p, "_vld.data_vld"}, 32'(got.data_vld), 32'(exp.data_vld));
    check({p, "_vld.fwd_vld"}, 32'(got.fwd_vld), 32'(exp.fwd_vld));
    check({p, "_vld.mfvr_vld"}, 32'(got.mfvr_vld), 32'(exp.mfvr_vld));
    // Select masked while EX1 is empty
    check({p, "_eu_sel"}, 32'(got_sel), 32'(exp.inst_vld[0] ? q : '0));
  endtask

  //------------------------------------------------------------
  // Stimulus helpers
  //------------------------------------------------------------

  function automatic issue_t rf_iss(int unsigned unit, logic dst);
    issue_t i;
    i = '0;
    i.rf_sel = 1'b1;
    i.rf_eu_sel = eu_sel_t'(1) << unit;
    i.dst_vld = dst;
    return i;
  endfunction

  function automatic issue_t mtvr_iss(mtvr_inst_t op, logic dst);
    issue_t i;
    i = '0;
    i.mtvr_vld = 1'b1;
    i.mtvr_inst = op;
    i.dst_vld = dst;
    return i;
  endfunction

  function automatic issue_t rand_issue();
    issue_t      i;
    logic [31:0] r;
    r = $urandom();
    i.rf_sel = r[0];
    // mtvr less often, sometimes together with rf issue
    i.mtvr_vld = r[1] & r[2];
    i.rf_eu_sel = eu_sel_t'(1) << (r[7:4] % 4'd12);
    i.mtvr_inst = r[12:8];
    i.dst_vld = r[13];
    return i;
  endfunction

  task automatic add_row(logic fl, issue_t i6, issue_t i7, dp_pre_t pre, div_ret_t d6,
                         logic [4:0] exp);
    row_t row;
    row.flush = fl;
    row.iss6 = i6;
    row.iss7 = i7;
    row.pre6 = pre;
    row.pre7 = pre;
    row.div6 = d6;
    row.exp_en = 1'b1;
    row.exp6_inst = exp;
    rows.push_back(row);
  endtask

  task automatic apply_row(row_t row);
    @(negedge ctrl_ex1_pipe6_clk);
    flush = row.flush;
    pipe6_issue = row.iss6;
    pipe7_issue = row.iss7;
    pipe6_dp_pre = row.pre6;
    pipe7_dp_pre = row.pre7;
    pipe6_div_ret = row.div6;
    #1;
    // Early FMA select lives in the issue cycle
    check("pipe6_fmau_sel", 32'(pipe6_fmau_sel), 32'(exp_fmau(row.iss6)));
    check("pipe7_fmau_sel", 32'(pipe7_fmau_sel), 32'(exp_fmau(row.iss7)));
    @(posedge ctrl_ex1_pipe6_clk);
    if (row.flush)
    begin
      m6 = '0;
      m7 = '0;
      q6 = '0;
      q7 = '0;
    end
    else
    begin
      m6 = next_vld(m6, row.iss6, row.pre6, row.div6);
      m7 = next_vld(m7, row.iss7, row.pre7, DIV_NONE);
      q6 = pick_sel(row.iss6);
      q7 = pick_sel(row.iss7);
    end
    #1;
    compare_pipe("pipe6", pipe6_vld, m6, pipe6_eu_sel, q6);
    compare_pipe("pipe7", pipe7_vld, m7, pipe7_eu_sel, q7);
    if (row.exp_en)
    begin
      check("pipe6_vld.inst_vld table", 32'(pipe6_vld.inst_vld), 32'(row.exp6_inst));
    end
  endtask

  //------------------------------------------------------------
  // Watchdog
  //------------------------------------------------------------

  initial
  begin
    wait (wd_limit != 64'd0);
    #(wd_limit);
    $display("Run timed out before all table rows were applied");
    $display("TB FAILED");
    $fatal(1, "Watchdog expired");
  end

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------

  initial
  begin
    row_t        row;
    logic [31:0] r;
    cpurst_b = 1'b0;
    flush = 1'b0;
    pipe6_issue = NO_ISS;
    pipe7_issue = NO_ISS;
    pipe6_dp_pre = PRE_NONE;
    pipe7_dp_pre = PRE_NONE;
    pipe6_div_ret = DIV_NONE;
    wd_limit = 64'd0;
    m6 = '0;
    m7 = '0;
    q6 = '0;
    q7 = '0;
    void'($urandom(32'h42f));

    // Single issue walking EX1..EX5, FMA on pipe 6
    add_row(1'b0, NO_ISS, NO_ISS, PRE_NONE, DIV_NONE, 5'b00000);
    add_row(1'b0, rf_iss(4, 1'b1), rf_iss(2, 1'b0), PRE_ALL, DIV_NONE, 5'b00001);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b00010);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b00100);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_MIX, DIV_NONE, 5'b01000);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b10000);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_NONE, DIV_NONE, 5'b00000);
    // Back to back, mtvr to ALU then MOV
    add_row(1'b0, mtvr_iss(5'b00001, 1'b1), NO_ISS, PRE_MIX, DIV_NONE, 5'b00001);
    add_row(1'b0, mtvr_iss(5'b01000, 1'b0), mtvr_iss(5'b10000, 1'b1), PRE_ALL,
            DIV_NONE, 5'b00011);
    add_row(1'b0, rf_iss(9, 1'b1), rf_iss(4, 1'b1), PRE_ALL, DIV_NONE, 5'b00111);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b01110);
    // Flush beats a new issue, then normal flow
    add_row(1'b1, rf_iss(4, 1'b1), rf_iss(1, 1'b1), PRE_ALL, DIV_NONE, 5'b00000);
    add_row(1'b0, rf_iss(4, 1'b0), rf_iss(4, 1'b0), PRE_MIX, DIV_NONE, 5'b00001);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b00010);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b00100);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b01000);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_NONE, DIV_NONE, 5'b10000);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_NONE, DIV_NONE, 5'b00000);
    // Divide returns on pipe 6 only, pipe 7 idle
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_EX2_DSU, 5'b00010);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_EX2_DIV, 5'b00110);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_EX5_DSU, 5'b11100);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b11000);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b10000);
    add_row(1'b0, NO_ISS, NO_ISS, PRE_ALL, DIV_NONE, 5'b00000);

    // Random phase, model only
    for (int n = 0; n < 200; n++)
    begin
      r = $urandom();
      row = '0;
      row.flush = (r[3:0] == 4'h0);
      row.iss6 = rand_issue();
      row.iss7 = rand_issue();
      row.pre6 = dp_pre_t'(r[8:4]);
      row.pre7 = dp_pre_t'(r[13:9]);
      row.div6 = (r[19:18] == 2'b00) ? div_ret_t'(r[16:14]) : DIV_NONE;
      rows.push_back(row);
    end

    // Rows plus reset plus margin, 10 ns each
    wd_limit = 64'(rows.size() + 30) * 64'd10;

    repeat (10) @(posedge ctrl_ex1_pipe6_clk);
    @(negedge ctrl_ex1_pipe6_clk);
    cpurst_b = 1'b1;
    #1;
    // Everything idle out of reset
    compare_pipe("pipe6", pipe6_vld, m6, pipe6_eu_sel, q6);
    compare_pipe("pipe7", pipe7_vld, m7, pipe7_eu_sel, q7);
    check("pipe6_fmau_sel", 32'(pipe6_fmau_sel), 32'd0);
    check("pipe7_fmau_sel", 32'(pipe7_fmau_sel), 32'd0);

    foreach (rows[k])
    begin
      apply_row(rows[k]);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- vfpu_ctrl.f
rtl/vfpu_eu_pkg.sv
rtl/vfpu_pipe_pkg.sv
rtl/vfpu_eu_sel.sv
rtl/vfpu_pipe_ctrl.sv
rtl/vfpu_ctrl.sv
dv/vfpu_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vfpu_ctrl testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f vfpu_ctrl.f \
  --top-module vfpu_ctrl_tb \
  -o vfpu_ctrl_sim

# The log decides the result, so a fatal exit is not fatal here
./obj_dir/vfpu_ctrl_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
